// ==== common/l2_pkg.sv ====
package l2_pkg;

    localparam int ADDR_BITS      = 32;
    localparam int WORD_BITS      = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_BITS    = 4;
    localparam int LINE_ADDR_BITS = ADDR_BITS - OFFSET_BITS;

    localparam int LINE_BITS      = WORDS_PER_LINE * WORD_BITS;

    typedef logic [ADDR_BITS-1:0]      addr_t;
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
    typedef logic [WORD_BITS-1:0]      word_t;
    typedef logic [LINE_BITS-1:0]      line_t;
    typedef logic [WORDS_PER_LINE-1:0] word_mask_t;
    typedef logic [2:0]                hsize_t;
    typedef logic [0:0]                hprot_t;
    typedef logic [1:0]                cpu_msg_t;
    typedef logic [4:0]                coh_msg_t;
    typedef logic [3:0]                req_id_t;
    typedef logic [3:0]                invack_cnt_t;

    // CPU request kinds
    localparam cpu_msg_t CPU_READ       = 2'b00;
    localparam cpu_msg_t CPU_READ_ATOM  = 2'b01;
    localparam cpu_msg_t CPU_WRITE      = 2'b10;
    localparam cpu_msg_t CPU_WRITE_ATOM = 2'b11;

    // Requests from L2 to the directory
    localparam coh_msg_t REQ_GETS   = 5'b00000;
    localparam coh_msg_t REQ_GETM   = 5'b00001;
    localparam coh_msg_t REQ_PUTS   = 5'b00010;
    localparam coh_msg_t REQ_PUTM   = 5'b00011;

    // Forwards from the directory
    localparam coh_msg_t FWD_GETS   = 5'b01000;
    localparam coh_msg_t FWD_GETM   = 5'b01001;
    localparam coh_msg_t FWD_INV    = 5'b01010;
    localparam coh_msg_t FWD_PUTACK = 5'b01011;

    // Responses
    localparam coh_msg_t RSP_S      = 5'b10000;
    localparam coh_msg_t RSP_DATA   = 5'b10001;
    localparam coh_msg_t RSP_EDATA  = 5'b10010;
    localparam coh_msg_t RSP_INVACK = 5'b10011;

    typedef struct packed {
        cpu_msg_t cpu_msg;
        hsize_t   hsize;
        hprot_t   hprot;
        addr_t    addr;
        word_t    word;
    } cpu_req_t;

    typedef struct packed {
        coh_msg_t   coh_msg;
        line_addr_t addr;
        req_id_t    req_id;
        line_t      line;
        word_mask_t word_mask;
    } fwd_in_t;

    typedef struct packed {
        coh_msg_t    coh_msg;
        line_addr_t  addr;
        line_t       line;
        word_mask_t  word_mask;
        invack_cnt_t invack_cnt;
    } rsp_in_t;

    typedef struct packed {
        coh_msg_t   coh_msg;
        hprot_t     hprot;
        line_addr_t addr;
        line_t      line;
        word_mask_t word_mask;
    } req_out_t;

    typedef struct packed {
        coh_msg_t   coh_msg;
        req_id_t    req_id;
        logic       to_req;
        line_addr_t addr;
        line_t      line;
        word_mask_t word_mask;
    } rsp_out_t;

endpackage

// ==== hw/skid_buffer.sv ====
`timescale 1ns/10ps

module skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,

    // Producer side
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t payload_i,

    // Consumer side
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t payload_o,

    output logic     held_o
);

    logic     held_q;
    payload_t store_q;
    logic     take_in;
    logic     park;

    assign take_in = valid_i && ready_o;

    // Accepted but the consumer cannot take it this cycle
    assign park = take_in && !ready_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            held_q <= 1'b0;
        end else if (held_q && ready_i) begin
            held_q <= 1'b0;
        end else if (park) begin
            held_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (park) begin
            store_q <= payload_i;
        end
    end

    // Empty buffer always accepts and a full one stalls the producer
    assign ready_o   = !held_q;
    assign valid_o   = valid_i || held_q;
    assign payload_o = held_q ? store_q : payload_i;
    assign held_o    = held_q;

endmodule

// ==== hw/l2_inputs/cpu_req_stage.sv ====
`timescale 1ns/10ps

module cpu_req_stage import l2_pkg::*; (
    input  logic     clk,
    input  logic     rst,

    input  logic     cpu_req_valid_i,
    output logic     cpu_req_ready_o,
    input  cpu_req_t cpu_req_i,

    output logic     cpu_req_valid_int_o,
    input  logic     cpu_req_ready_int_i,

    input  logic     set_cpu_req_conflict_i,
    input  logic     set_cpu_req_from_conflict_i,

    output cpu_req_t cpu_req_o,
    output addr_t    cpu_req_addr_o
);

    cpu_req_t cpu_req_buf;
    cpu_req_t cpu_req_conflict;
    logic     cpu_req_held;
    addr_t    buf_addr;

    skid_buffer #(
        .payload_t(cpu_req_t)
    ) i_cpu_req_buf (
        .clk       (clk),
        .rst       (rst),
        .valid_i   (cpu_req_valid_i),
        .ready_o   (cpu_req_ready_o),
        .payload_i (cpu_req_i),
        .valid_o   (cpu_req_valid_int_o),
        .ready_i   (cpu_req_ready_int_i),
        .payload_o (cpu_req_buf),
        .held_o    (cpu_req_held)
    );

    // Replay of the conflict copy wins over a new transfer
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cpu_req_o <= '0;
        end else if (set_cpu_req_from_conflict_i) begin
            cpu_req_o <= cpu_req_conflict;
        end else if (cpu_req_valid_int_o && cpu_req_ready_int_i) begin
            cpu_req_o <= cpu_req_buf;
        end
    end

    // Request parked because its set was busy
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cpu_req_conflict <= '0;
        end else if (set_cpu_req_conflict_i) begin
            cpu_req_conflict <= cpu_req_o;
        end
    end

    assign buf_addr = cpu_req_held ? cpu_req_buf.addr : cpu_req_i.addr;

    // Set lookup address ahead of the latch update
    assign cpu_req_addr_o = set_cpu_req_from_conflict_i ? cpu_req_conflict.addr : buf_addr;

endmodule

// ==== hw/l2_inputs/fwd_in_stage.sv ====
`timescale 1ns/10ps

module fwd_in_stage import l2_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  logic       fwd_in_valid_i,
    output logic       fwd_in_ready_o,
    input  fwd_in_t    fwd_in_i,

    output logic       fwd_in_valid_int_o,
    input  logic       fwd_in_ready_int_i,

    input  logic       set_fwd_in_stalled_i,
    input  logic       set_fwd_in_from_stalled_i,

    output fwd_in_t    fwd_in_o,
    output line_addr_t fwd_in_addr_o,
    output line_addr_t fwd_in_tmp_addr_o
);

    fwd_in_t    fwd_in_buf;
    fwd_in_t    fwd_in_stalled;
    logic       fwd_in_held;
    line_addr_t incoming_addr;

    skid_buffer #(
        .payload_t(fwd_in_t)
    ) i_fwd_in_buf (
        .clk       (clk),
        .rst       (rst),
        .valid_i   (fwd_in_valid_i),
        .ready_o   (fwd_in_ready_o),
        .payload_i (fwd_in_i),
        .valid_o   (fwd_in_valid_int_o),
        .ready_i   (fwd_in_ready_int_i),
        .payload_o (fwd_in_buf),
        .held_o    (fwd_in_held)
    );

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fwd_in_o <= '0;
        end else if (set_fwd_in_from_stalled_i) begin
            fwd_in_o <= fwd_in_stalled;
        end else if (fwd_in_valid_int_o && fwd_in_ready_int_i) begin
            fwd_in_o <= fwd_in_buf;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            fwd_in_stalled <= '0;
        end else if (set_fwd_in_stalled_i) begin
            fwd_in_stalled <= fwd_in_o;
        end
    end

    assign incoming_addr = fwd_in_held ? fwd_in_buf.addr : fwd_in_i.addr;

    // Address of the next forward regardless of any stalled one
    assign fwd_in_tmp_addr_o = incoming_addr;
    assign fwd_in_addr_o     = set_fwd_in_from_stalled_i ? fwd_in_stalled.addr : incoming_addr;

endmodule

// ==== hw/l2_inputs/rsp_in_stage.sv ====
`timescale 1ns/10ps

module rsp_in_stage import l2_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    input  logic       rsp_in_valid_i,
    output logic       rsp_in_ready_o,
    input  rsp_in_t    rsp_in_i,

    output logic       rsp_in_valid_int_o,
    input  logic       rsp_in_ready_int_i,

    output rsp_in_t    rsp_in_o,
    output line_addr_t rsp_in_addr_o
);

    rsp_in_t rsp_in_buf;
    logic    rsp_in_held;

    skid_buffer #(
        .payload_t(rsp_in_t)
    ) i_rsp_in_buf (
        .clk       (clk),
        .rst       (rst),
        .valid_i   (rsp_in_valid_i),
        .ready_o   (rsp_in_ready_o),
        .payload_i (rsp_in_i),
        .valid_o   (rsp_in_valid_int_o),
        .ready_i   (rsp_in_ready_int_i),
        .payload_o (rsp_in_buf),
        .held_o    (rsp_in_held)
    );

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rsp_in_o <= '0;
        end else if (rsp_in_valid_int_o && rsp_in_ready_int_i) begin
            rsp_in_o <= rsp_in_buf;
        end
    end

    assign rsp_in_addr_o = rsp_in_held ? rsp_in_buf.addr : rsp_in_i.addr;

endmodule

// ==== hw/l2_channel_buffers.sv ====
`timescale 1ns/10ps

module l2_channel_buffers import l2_pkg::*; (
    input  logic       clk,
    input  logic       rst,

    // CPU request in
    input  logic       cpu_req_valid_i,
    output logic       cpu_req_ready_o,
    input  cpu_req_t   cpu_req_i,
    output logic       cpu_req_valid_int_o,
    input  logic       cpu_req_ready_int_i,
    input  logic       set_cpu_req_conflict_i,
    input  logic       set_cpu_req_from_conflict_i,
    output cpu_req_t   cpu_req_o,
    output addr_t      cpu_req_addr_o,

    // Forward in
    input  logic       fwd_in_valid_i,
    output logic       fwd_in_ready_o,
    input  fwd_in_t    fwd_in_i,
    output logic       fwd_in_valid_int_o,
    input  logic       fwd_in_ready_int_i,
    input  logic       set_fwd_in_stalled_i,
    input  logic       set_fwd_in_from_stalled_i,
    output fwd_in_t    fwd_in_o,
    output line_addr_t fwd_in_addr_o,
    output line_addr_t fwd_in_tmp_addr_o,

    // Response in
    input  logic       rsp_in_valid_i,
    output logic       rsp_in_ready_o,
    input  rsp_in_t    rsp_in_i,
    output logic       rsp_in_valid_int_o,
    input  logic       rsp_in_ready_int_i,
    output rsp_in_t    rsp_in_o,
    output line_addr_t rsp_in_addr_o,

    // Request out
    input  logic       req_out_valid_int_i,
    output logic       req_out_ready_int_o,
    input  req_out_t   req_out_int_i,
    output logic       req_out_valid_o,
    input  logic       req_out_ready_i,
    output req_out_t   req_out_o,

    // Response out
    input  logic       rsp_out_valid_int_i,
    output logic       rsp_out_ready_int_o,
    input  rsp_out_t   rsp_out_int_i,
    output logic       rsp_out_valid_o,
    input  logic       rsp_out_ready_i,
    output rsp_out_t   rsp_out_o
);

    cpu_req_stage i_cpu_req_stage (
        .clk                         (clk),
        .rst                         (rst),
        .cpu_req_valid_i             (cpu_req_valid_i),
        .cpu_req_ready_o             (cpu_req_ready_o),
        .cpu_req_i                   (cpu_req_i),
        .cpu_req_valid_int_o         (cpu_req_valid_int_o),
        .cpu_req_ready_int_i         (cpu_req_ready_int_i),
        .set_cpu_req_conflict_i      (set_cpu_req_conflict_i),
        .set_cpu_req_from_conflict_i (set_cpu_req_from_conflict_i),
        .cpu_req_o                   (cpu_req_o),
        .cpu_req_addr_o              (cpu_req_addr_o)
    );

    fwd_in_stage i_fwd_in_stage (
        .clk                       (clk),
        .rst                       (rst),
        .fwd_in_valid_i            (fwd_in_valid_i),
        .fwd_in_ready_o            (fwd_in_ready_o),
        .fwd_in_i                  (fwd_in_i),
        .fwd_in_valid_int_o        (fwd_in_valid_int_o),
        .fwd_in_ready_int_i        (fwd_in_ready_int_i),
        .set_fwd_in_stalled_i      (set_fwd_in_stalled_i),
        .set_fwd_in_from_stalled_i (set_fwd_in_from_stalled_i),
        .fwd_in_o                  (fwd_in_o),
        .fwd_in_addr_o             (fwd_in_addr_o),
        .fwd_in_tmp_addr_o         (fwd_in_tmp_addr_o)
    );

    rsp_in_stage i_rsp_in_stage (
        .clk                (clk),
        .rst                (rst),
        .rsp_in_valid_i     (rsp_in_valid_i),
        .rsp_in_ready_o     (rsp_in_ready_o),
        .rsp_in_i           (rsp_in_i),
        .rsp_in_valid_int_o (rsp_in_valid_int_o),
        .rsp_in_ready_int_i (rsp_in_ready_int_i),
        .rsp_in_o           (rsp_in_o),
        .rsp_in_addr_o      (rsp_in_addr_o)
    );

    // Output channels driven by the controller side
    skid_buffer #(
        .payload_t(req_out_t)
    ) i_req_out_buf (
        .clk       (clk),
        .rst       (rst),
        .valid_i   (req_out_valid_int_i),
        .ready_o   (req_out_ready_int_o),
        .payload_i (req_out_int_i),
        .valid_o   (req_out_valid_o),
        .ready_i   (req_out_ready_i),
        .payload_o (req_out_o),
        .held_o    ()
    );

    skid_buffer #(
        .payload_t(rsp_out_t)
    ) i_rsp_out_buf (
        .clk       (clk),
        .rst       (rst),
        .valid_i   (rsp_out_valid_int_i),
        .ready_o   (rsp_out_ready_int_o),
        .payload_i (rsp_out_int_i),
        .valid_o   (rsp_out_valid_o),
        .ready_i   (rsp_out_ready_i),
        .payload_o (rsp_out_o),
        .held_o    ()
    );

endmodule

// ==== dv/l2_channel_buffers_asserts.sv ====
`timescale 1ns/10ps

module l2_channel_buffers_asserts import l2_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     cpu_req_ready_o,
    input logic     cpu_req_ready_int_i,
    input logic     req_out_valid_o,
    input logic     req_out_ready_i,
    input req_out_t req_out_o,
    input logic     rsp_out_valid_o,
    input logic     rsp_out_ready_i,
    input rsp_out_t rsp_out_o
);

    int fail_count = 0;

    // Stalled output keeps valid and payload
    req_out_hold: assert property (@(posedge clk) disable iff (!rst)
        req_out_valid_o && !req_out_ready_i |=> req_out_valid_o && $stable(req_out_o))
    else begin
        fail_count++;
        $error("req_out changed while stalled");
    end

    rsp_out_hold: assert property (@(posedge clk) disable iff (!rst)
        rsp_out_valid_o && !rsp_out_ready_i |=> rsp_out_valid_o && $stable(rsp_out_o))
    else begin
        fail_count++;
        $error("rsp_out changed while stalled");
    end

    // Buffer is empty after a cycle with the controller ready
    cpu_req_ready_back: assert property (@(posedge clk) disable iff (!rst)
        cpu_req_ready_int_i |=> cpu_req_ready_o)
    else begin
        fail_count++;
        $error("cpu_req_ready_o low after internal ready");
    end

endmodule

bind l2_channel_buffers l2_channel_buffers_asserts i_asserts (
    .clk                 (clk),
    .rst                 (rst),
    .cpu_req_ready_o     (cpu_req_ready_o),
    .cpu_req_ready_int_i (cpu_req_ready_int_i),
    .req_out_valid_o     (req_out_valid_o),
    .req_out_ready_i     (req_out_ready_i),
    .req_out_o           (req_out_o),
    .rsp_out_valid_o     (rsp_out_valid_o),
    .rsp_out_ready_i     (rsp_out_ready_i),
    .rsp_out_o           (rsp_out_o)
);

// ==== dv/tb_l2_channel_buffers.sv ====
`timescale 1ns/10ps

module tb_l2_channel_buffers import l2_pkg::*; ();

    localparam int TIMEOUT = 50;
    localparam int STREAM_LEN = 16;

    logic       clk;
    logic       rst;

    logic       cpu_req_valid_i, cpu_req_ready_o, cpu_req_valid_int_o, cpu_req_ready_int_i;
    logic       set_cpu_req_conflict_i, set_cpu_req_from_conflict_i;
    cpu_req_t   cpu_req_i, cpu_req_o;
    addr_t      cpu_req_addr_o;

    logic       fwd_in_valid_i, fwd_in_ready_o, fwd_in_valid_int_o, fwd_in_ready_int_i;
    logic       set_fwd_in_stalled_i, set_fwd_in_from_stalled_i;
    fwd_in_t    fwd_in_i, fwd_in_o;
    line_addr_t fwd_in_addr_o, fwd_in_tmp_addr_o;

    logic       rsp_in_valid_i, rsp_in_ready_o, rsp_in_valid_int_o, rsp_in_ready_int_i;
    rsp_in_t    rsp_in_i, rsp_in_o;
    line_addr_t rsp_in_addr_o;

    logic       req_out_valid_int_i, req_out_ready_int_o, req_out_valid_o, req_out_ready_i;
    req_out_t   req_out_int_i, req_out_o;
    logic       rsp_out_valid_int_i, rsp_out_ready_int_o, rsp_out_valid_o, rsp_out_ready_i;
    rsp_out_t   rsp_out_int_i, rsp_out_o;

    int          errors = 0;
    int          failures = 0;
    logic [31:0] lfsr;

    l2_channel_buffers i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [191:0] rand_bits(input int n);
        logic [191:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = next_lfsr(lfsr);
            v = {v[190:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic report_mismatch(input string name, input string got, input string exp);
        $display("** Error: %s is 0x%s, expected 0x%s", name, got, exp);
        errors++;
    endtask

    task automatic check_cpu_req(input string name, input cpu_req_t got, input cpu_req_t exp);
        if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_fwd_in(input string name, input fwd_in_t got, input fwd_in_t exp);
        if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_rsp_in(input string name, input rsp_in_t got, input rsp_in_t exp);
        if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_req_out(input string name, input req_out_t got, input req_out_t exp);
        if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_rsp_out(input string name, input rsp_out_t got, input rsp_out_t exp);
        if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_line_addr(input string name, input line_addr_t got,
                                   input line_addr_t exp);
        if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) report_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    endtask

    // Returns at the falling edge before the accepting edge
    task automatic await_accept(input int ch);
        int   n;
        logic hit;
        n = 0;
        hit = 1'b0;
        while (!hit && n < TIMEOUT) begin
            @(negedge clk);
            case (ch)
                0: hit = cpu_req_valid_i && cpu_req_ready_o;
                1: hit = fwd_in_valid_i && fwd_in_ready_o;
                default: hit = rsp_in_valid_i && rsp_in_ready_o;
            endcase
            n++;
        end
        if (!hit) begin
            $display("Timeout: input channel %0d never accepted its request", ch);
            failures++;
        end
    endtask

    task automatic latch_cpu_req(input cpu_req_t a);
        @(posedge clk);
        cpu_req_ready_int_i <= 1'b1;
        cpu_req_valid_i     <= 1'b1;
        cpu_req_i           <= a;
        await_accept(0);
        check_bit("cpu_req_valid_int_o", cpu_req_valid_int_o, 1'b1);
        check_addr("cpu_req_addr_o", cpu_req_addr_o, a.addr);
        @(posedge clk);
        cpu_req_valid_i <= 1'b0;
        @(negedge clk);
        check_cpu_req("cpu_req_o", cpu_req_o, a);
    endtask

    task automatic latch_fwd_in(input fwd_in_t a);
        @(posedge clk);
        fwd_in_ready_int_i <= 1'b1;
        fwd_in_valid_i     <= 1'b1;
        fwd_in_i           <= a;
        await_accept(1);
        check_bit("fwd_in_valid_int_o", fwd_in_valid_int_o, 1'b1);
        check_line_addr("fwd_in_addr_o", fwd_in_addr_o, a.addr);
        check_line_addr("fwd_in_tmp_addr_o", fwd_in_tmp_addr_o, a.addr);
        @(posedge clk);
        fwd_in_valid_i <= 1'b0;
        @(negedge clk);
        check_fwd_in("fwd_in_o", fwd_in_o, a);
    endtask

    task automatic test_pass_through();
        logic [191:0] v;
        v = rand_bits($bits(cpu_req_t));
        latch_cpu_req(v[$bits(cpu_req_t)-1:0]);
    endtask

    task automatic test_input_backpressure();
        cpu_req_t     a;
        cpu_req_t     b;
        logic [191:0] v;
        v = rand_bits($bits(cpu_req_t));
        a = v[$bits(cpu_req_t)-1:0];
        v = rand_bits($bits(cpu_req_t));
        b = v[$bits(cpu_req_t)-1:0];
        @(posedge clk);
        cpu_req_ready_int_i <= 1'b0;
        cpu_req_valid_i     <= 1'b1;
        cpu_req_i           <= a;
        await_accept(0);
        @(posedge clk);
        cpu_req_valid_i <= 1'b0;
        cpu_req_i       <= b;
        @(negedge clk);
        check_bit("cpu_req_ready_o", cpu_req_ready_o, 1'b0);
        check_bit("cpu_req_valid_int_o", cpu_req_valid_int_o, 1'b1);
        check_addr("cpu_req_addr_o", cpu_req_addr_o, a.addr);
        @(posedge clk);
        cpu_req_ready_int_i <= 1'b1;
        // Stored item drains into the latch on the next edge
        @(posedge clk);
        @(negedge clk);
        check_cpu_req("cpu_req_o", cpu_req_o, a);
        check_bit("cpu_req_ready_o", cpu_req_ready_o, 1'b1);
    endtask

    task automatic test_conflict_replay();
        cpu_req_t     a;
        cpu_req_t     c;
        logic [191:0] v;
        v = rand_bits($bits(cpu_req_t));
        a = v[$bits(cpu_req_t)-1:0];
        latch_cpu_req(a);
        @(posedge clk);
        set_cpu_req_conflict_i <= 1'b1;
        @(posedge clk);
        set_cpu_req_conflict_i <= 1'b0;
        v = rand_bits($bits(cpu_req_t));
        latch_cpu_req(v[$bits(cpu_req_t)-1:0]);
        v = rand_bits($bits(cpu_req_t));
        c = v[$bits(cpu_req_t)-1:0];
        // Replay and a new transfer on the same edge
        @(posedge clk);
        set_cpu_req_from_conflict_i <= 1'b1;
        cpu_req_valid_i             <= 1'b1;
        cpu_req_i                   <= c;
        await_accept(0);
        check_addr("cpu_req_addr_o", cpu_req_addr_o, a.addr);
        @(posedge clk);
        set_cpu_req_from_conflict_i <= 1'b0;
        cpu_req_valid_i             <= 1'b0;
        @(negedge clk);
        check_cpu_req("cpu_req_o", cpu_req_o, a);
    endtask

    task automatic test_fwd_stall_replay();
        fwd_in_t      a;
        fwd_in_t      c;
        logic [191:0] v;
        v = rand_bits($bits(fwd_in_t));
        a = v[$bits(fwd_in_t)-1:0];
        latch_fwd_in(a);
        @(posedge clk);
        set_fwd_in_stalled_i <= 1'b1;
        @(posedge clk);
        set_fwd_in_stalled_i <= 1'b0;
        v = rand_bits($bits(fwd_in_t));
        latch_fwd_in(v[$bits(fwd_in_t)-1:0]);
        v = rand_bits($bits(fwd_in_t));
        c = v[$bits(fwd_in_t)-1:0];
        @(posedge clk);
        set_fwd_in_from_stalled_i <= 1'b1;
        fwd_in_valid_i            <= 1'b1;
        fwd_in_i                  <= c;
        await_accept(1);
        check_line_addr("fwd_in_addr_o", fwd_in_addr_o, a.addr);
        check_line_addr("fwd_in_tmp_addr_o", fwd_in_tmp_addr_o, c.addr);
        @(posedge clk);
        set_fwd_in_from_stalled_i <= 1'b0;
        fwd_in_valid_i            <= 1'b0;
        @(negedge clk);
        check_fwd_in("fwd_in_o", fwd_in_o, a);
    endtask

    task automatic test_rsp_in_latch();
        rsp_in_t      r;
        logic [191:0] v;
        for (int k = 0; k < 6; k++) begin
            v = rand_bits($bits(rsp_in_t));
            r = v[$bits(rsp_in_t)-1:0];
            @(posedge clk);
            rsp_in_ready_int_i <= 1'b1;
            rsp_in_valid_i     <= 1'b1;
            rsp_in_i           <= r;
            await_accept(2);
            check_bit("rsp_in_valid_int_o", rsp_in_valid_int_o, 1'b1);
            check_line_addr("rsp_in_addr_o", rsp_in_addr_o, r.addr);
            @(posedge clk);
            rsp_in_valid_i <= 1'b0;
            @(negedge clk);
            check_rsp_in("rsp_in_o", rsp_in_o, r);
        end
    endtask

    task automatic test_output_stream();
        req_out_t     req_q[$];
        rsp_out_t     rsp_q[$];
        int           req_tx, req_rx, rsp_tx, rsp_rx, n;
        logic [191:0] v;
        for (int k = 0; k < STREAM_LEN; k++) begin
            v = rand_bits($bits(req_out_t));
            req_q.push_back(v[$bits(req_out_t)-1:0]);
            v = rand_bits($bits(rsp_out_t));
            rsp_q.push_back(v[$bits(rsp_out_t)-1:0]);
        end
        req_tx = 0;
        req_rx = 0;
        rsp_tx = 0;
        rsp_rx = 0;
        n = 0;
        while ((req_rx < STREAM_LEN || rsp_rx < STREAM_LEN) && n < 20 * TIMEOUT) begin
            @(posedge clk);
            v = rand_bits(2);
            req_out_ready_i     <= v[0];
            rsp_out_ready_i     <= v[1];
            req_out_valid_int_i <= (req_tx < STREAM_LEN);
            req_out_int_i       <= (req_tx < STREAM_LEN) ? req_q[req_tx] : '0;
            rsp_out_valid_int_i <= (rsp_tx < STREAM_LEN);
            rsp_out_int_i       <= (rsp_tx < STREAM_LEN) ? rsp_q[rsp_tx] : '0;
            @(negedge clk);
            if (req_out_valid_o && req_out_ready_i) begin
                if (req_rx < STREAM_LEN) check_req_out("req_out_o", req_out_o, req_q[req_rx]);
                req_rx++;
            end
            if (rsp_out_valid_o && rsp_out_ready_i) begin
                if (rsp_rx < STREAM_LEN) check_rsp_out("rsp_out_o", rsp_out_o, rsp_q[rsp_rx]);
                rsp_rx++;
            end
            if (req_out_valid_int_i && req_out_ready_int_o) req_tx++;
            if (rsp_out_valid_int_i && rsp_out_ready_int_o) rsp_tx++;
            n++;
        end
        if (req_rx != STREAM_LEN || rsp_rx != STREAM_LEN) begin
            $display("Output stream delivered %0d requests and %0d responses, sent %0d each",
                     req_rx, rsp_rx, STREAM_LEN);
            failures++;
        end
        @(posedge clk);
        req_out_valid_int_i <= 1'b0;
        rsp_out_valid_int_i <= 1'b0;
        req_out_ready_i     <= 1'b0;
        rsp_out_ready_i     <= 1'b0;
        @(negedge clk);
        check_bit("req_out_valid_o", req_out_valid_o, 1'b0);
        check_bit("rsp_out_valid_o", rsp_out_valid_o, 1'b0);
    endtask

    initial begin
        lfsr = 32'hfb97ab62;
        rst = 1'b0;
        {cpu_req_valid_i, cpu_req_ready_int_i} = '0;
        {set_cpu_req_conflict_i, set_cpu_req_from_conflict_i} = '0;
        cpu_req_i = '0;
        {fwd_in_valid_i, fwd_in_ready_int_i} = '0;
        {set_fwd_in_stalled_i, set_fwd_in_from_stalled_i} = '0;
        fwd_in_i = '0;
        {rsp_in_valid_i, rsp_in_ready_int_i} = '0;
        rsp_in_i = '0;
        {req_out_valid_int_i, req_out_ready_i, rsp_out_valid_int_i, rsp_out_ready_i} = '0;
        req_out_int_i = '0;
        rsp_out_int_i = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;

        test_pass_through();
        test_input_backpressure();
        test_conflict_replay();
        test_fwd_stall_replay();
        test_rsp_in_latch();
        test_output_stream();

        repeat (2) @(posedge clk);
        $display("Mismatches: %0d, other failures: %0d, assertion failures: %0d",
                 errors, failures, i_dut.i_asserts.fail_count);
        if (errors == 0 && failures == 0 && i_dut.i_asserts.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
common/l2_pkg.sv
hw/skid_buffer.sv
hw/l2_inputs/cpu_req_stage.sv
hw/l2_inputs/fwd_in_stage.sv
hw/l2_inputs/rsp_in_stage.sv
hw/l2_channel_buffers.sv
dv/l2_channel_buffers_asserts.sv
dv/tb_l2_channel_buffers.sv

// ==== run.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --assert --top-module tb_l2_channel_buffers \
    -f compile.f -o tb_l2_channel_buffers > build.log 2>&1 \
    && ./obj_dir/tb_l2_channel_buffers +verilator+error+limit+1000 > sim.log 2>&1

cat build.log sim.log 2>/dev/null

grep -qx "All tests passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
